/* polyline_cases.txt */
# test <name> <colour hex> <mode 0 plain, 1 replot while busy, 2 stray writes first>
# pt <x> <y> point for the buffer; px <x> <y> expected pixel in order; end closes a test
test horiz f800 0
pt 2 3
pt 6 3
pt 6 3
px 2 3
px 3 3
px 4 3
px 5 3
px 6 3
px 6 3
end
test steep 07e0 0
pt 10 10
pt 8 4
px 10 10
px 10 9
px 9 8
px 9 7
px 9 6
px 8 5
px 8 4
end
test shallow 001f 0
pt 0 5
pt 4 3
px 0 5
px 1 4
px 2 4
px 3 3
px 4 3
end
test triangle ffff 0
pt 1 1
pt 3 1
pt 3 3
pt 1 1
px 1 1
px 2 1
px 3 1
px 3 1
px 3 2
px 3 3
px 3 3
px 2 2
px 1 1
end
test replot 1234 1
pt 0 0
pt 3 0
px 0 0
px 1 0
px 2 0
px 3 0
end
test stray abcd 2
pt 5 5
pt 5 7
px 5 5
px 5 6
px 5 7
end
test short 4321 0
pt 9 9
end

/* flist.f */
polyline_pkg.sv
spi_write_slave.sv
polyline_regs.sv
line_raster.sv
lcd_pixel_writer.sv
draw_polyline.sv
polyline_top.sv
polyline_checker.sv
tb_polyline.sv

/* tb_polyline.sv */
`timescale 1ns/1ns
`default_nettype none
module tb_polyline;
  import polyline_pkg::*;

  localparam int clk_div = 2;

  logic clk = 1'b0;
  logic arst_n;
  logic spi_csn, spi_sclk, spi_mosi;
  wire  spi_busy;
  wire  lcd_sclk, lcd_mosi, lcd_dc, lcd_csn, lcd_resn;

  // test table, read from the cases file
  string       t_name [$];
  logic [15:0] t_color [$];
  int          t_mode [$];   // 0 plain, 1 replot during busy, 2 stray writes
  int          t_pt_first [$], t_pt_cnt [$];
  int          t_px_first [$], t_px_cnt [$];
  logic [15:0] pt_x [$], pt_y [$];
  logic [15:0] px_x [$], px_y [$];

  logic [7:0]  frame_q [$];  // data bytes of the next spi frame
  int          tb_errors  = 0;
  int          busy_rises = 0;
  logic        busy_d     = 1'b0;
  int          cycles     = 0;
  int          limit      = 0; // 0 until the cases are read
  int          passed     = 0;
  int          failed     = 0;

  always #5 clk = ~clk;

  polyline_top #(.clk_div(clk_div)) polyline_top_inst (
    .clk(clk), .arst_n(arst_n),
    .spi_csn(spi_csn), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
    .spi_busy(spi_busy),
    .lcd_sclk(lcd_sclk), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc),
    .lcd_csn(lcd_csn), .lcd_resn(lcd_resn)
  );

  polyline_checker polyline_checker_inst (
    .lcd_sclk(lcd_sclk), .lcd_mosi(lcd_mosi), .lcd_dc(lcd_dc),
    .lcd_csn(lcd_csn), .spi_busy(spi_busy)
  );

  // busy edges and the run limit
  always @(posedge clk) begin
    cycles++;
    busy_d <= spi_busy;
    if (spi_busy && !busy_d)
      busy_rises++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, spi_busy never fell or the run stalled", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #1; // inputs move just after the edge
  endtask

  // ******************************
  // host spi master, sclk half period 4 clk
  task automatic send_byte(input logic [7:0] b);
    int i;
    int gap;
    for (i = 7; i >= 0; i--) begin
      spi_mosi = b[i];
      repeat (4) tick();
      spi_sclk = 1'b1; // slave samples here
      repeat (4) tick();
      spi_sclk = 1'b0;
    end
    gap = $urandom % 4; // idle gap between bytes
    repeat (gap) tick();
  endtask

  task automatic send_frame(input logic [7:0] op, input logic [31:0] a);
    int i;
    spi_csn = 1'b0;
    repeat (2) tick();
    send_byte(op);
    for (i = 3; i >= 0; i--)
      send_byte(a[8*i +: 8]);
    for (i = 0; i < frame_q.size(); i++)
      send_byte(frame_q[i]);
    repeat (4) tick();
    spi_csn = 1'b1;
    repeat (6) tick(); // long enough for the slave to see csn high
    frame_q.delete();
  endtask

  // ******************************
  // cases file
  task automatic read_cases();
    int    fd, n, x, y, col, mode;
    string line, key, name;
    fd = $fopen("polyline_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open polyline_cases.txt");
      $display("TESTS FAILED");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        n = $sscanf(line, "%s", key);
        if (n <= 0 || key.substr(0, 0) == "#")
          continue;
        if (key == "test") begin
          n = $sscanf(line, "%s %s %h %d", key, name, col, mode);
          t_name.push_back(name);
          t_color.push_back(col[15:0]);
          t_mode.push_back(mode);
          t_pt_first.push_back(pt_x.size());
          t_px_first.push_back(px_x.size());
        end else if (key == "pt" || key == "px") begin
          n = $sscanf(line, "%s %d %d", key, x, y);
          if (key == "pt") begin
            pt_x.push_back(x[15:0]);
            pt_y.push_back(y[15:0]);
          end else begin
            px_x.push_back(x[15:0]);
            px_y.push_back(y[15:0]);
          end
        end else if (key == "end") begin
          t_pt_cnt.push_back(pt_x.size() - t_pt_first[$]);
          t_px_cnt.push_back(px_x.size() - t_px_first[$]);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int t);
    int          i, e0, len;
    logic [15:0] c;
    e0 = tb_errors + polyline_checker_inst.errors;
    c  = t_color[t];
    busy_rises = 0;
    polyline_checker_inst.cur_test = t_name[t];
    for (i = 0; i < t_px_cnt[t]; i++)
      polyline_checker_inst.exp_q.push_back(
        {px_x[t_px_first[t]+i], px_y[t_px_first[t]+i], c});
    for (i = 0; i < t_pt_cnt[t]; i++) begin
      frame_q.push_back(pt_x[t_pt_first[t]+i][15:8]);
      frame_q.push_back(pt_x[t_pt_first[t]+i][7:0]);
      frame_q.push_back(pt_y[t_pt_first[t]+i][15:8]);
      frame_q.push_back(pt_y[t_pt_first[t]+i][7:0]);
    end
    send_frame(op_write, {page_points, 16'h0000});
    if (t_mode[t] == 2) begin
      frame_q = '{8'h12, 8'h34, 8'h00, 8'h10}; // would plot if reads were applied
      send_frame(op_read, {page_regs, 16'h0000});
      frame_q = '{8'h55, 8'h55, 8'h55, 8'h55, 8'h55, 8'h55, 8'h55, 8'h55};
      send_frame(op_read, {page_points, 16'h0000});
      frame_q = '{8'h66, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66};
      send_frame(op_write, {16'h1cdc, 16'h0000});
      frame_q = '{8'h12, 8'h34, 8'h00, 8'h10}; // would plot on a loose page decode
      send_frame(op_write, {16'h1cdf, 16'h0000});
      if (busy_rises != 0) begin
        $display("test %s: stray writes started a plot", t_name[t]);
        tb_errors++;
      end
    end
    len = 4 * t_pt_cnt[t];
    frame_q = '{c[15:8], c[7:0], 8'(len >> 8), 8'(len)};
    send_frame(op_write, {page_regs, 16'h0000});
    if (t_mode[t] == 1) begin
      if (!spi_busy) begin
        $display("test %s: spi_busy was low right after the plot write", t_name[t]);
        tb_errors++;
      end
      frame_q = '{8'(len)};
      send_frame(op_write, {page_regs, 16'h0003}); // second plot while busy
      if (!spi_busy) begin
        $display("test %s: spi_busy fell before the repeated plot write ended", t_name[t]);
        tb_errors++;
      end
    end
    while (spi_busy)
      tick();
    polyline_checker_inst.close_test(); // every pixel must be out by now
    repeat (20) tick();
    if (busy_rises != 1) begin
      $display("test %s: spi_busy rose %0d times, once expected", t_name[t], busy_rises);
      tb_errors++;
    end
    if (tb_errors + polyline_checker_inst.errors == e0) begin
      $display("test %s: pass, %0d pixels", t_name[t], t_px_cnt[t]);
      passed++;
    end else begin
      $display("test %s: fail, %0d errors", t_name[t],
               tb_errors + polyline_checker_inst.errors - e0);
      failed++;
    end
  endtask

  // ******************************
  // main sequence
  initial begin
    int seed;
    int t;
    int total_px;
    seed     = $urandom(71916);
    arst_n   = 1'b0;
    spi_csn  = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    read_cases();
    total_px = px_x.size();
    limit = total_px * 13 * 8 * clk_div * 2 + 2000 * t_name.size();
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    tick();
    if (spi_busy !== 1'b0 || lcd_csn !== 1'b1 || lcd_sclk !== 1'b1 || lcd_resn !== 1'b1) begin
      $display("test reset: fail, outputs not idle after reset");
      tb_errors++;
      failed++;
    end else begin
      $display("test reset: pass");
      passed++;
    end
    for (t = 0; t < t_name.size(); t++)
      run_test(t);
    $display("tests %0d, passed %0d, failed %0d, errors %0d", passed + failed, passed,
             failed, tb_errors + polyline_checker_inst.errors);
    if (failed == 0 && tb_errors + polyline_checker_inst.errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
`default_nettype wire

/* polyline_checker.sv */
`timescale 1ns/1ns
`default_nettype none
module polyline_checker (
  input wire lcd_sclk,
  input wire lcd_mosi,
  input wire lcd_dc,
  input wire lcd_csn,
  input wire spi_busy
);
  import polyline_pkg::*;

  logic [47:0] exp_q [$];  // {x, y, colour}, filled by the testbench
  string       cur_test = "none";
  int          errors   = 0;
  int          pix_seen = 0;  // pixels decoded in the current test

  logic [7:0]  bytes_q [$];
  logic        dcs_q [$];
  logic [7:0]  sh;
  int          nbits    = 0;
  logic        in_frame = 1'b0;

  // ******************************
  // serial decode, one lcd frame per pixel
  always @(negedge lcd_csn) begin
    nbits    = 0;
    in_frame = 1'b1;
    bytes_q.delete();
    dcs_q.delete();
    if (!spi_busy) begin
      $display("test %s: lcd frame started while spi_busy was low", cur_test);
      errors++;
    end
  end

  always @(posedge lcd_sclk) begin
    if (lcd_csn === 1'b0) begin
      sh = {sh[6:0], lcd_mosi}; // msb first
      nbits++;
      if (nbits == 8) begin
        bytes_q.push_back(sh);
        dcs_q.push_back(lcd_dc); // dc is steady around the rising edge
        nbits = 0;
      end
    end
  end

  always @(posedge lcd_csn) begin
    if (in_frame) begin
      in_frame = 1'b0;
      check_frame();
    end
  end

  // ******************************
  // byte layout and pixel compare
  task automatic check_frame();
    logic [15:0] x, y, c;
    logic [47:0] exp;
    int          i;
    if (bytes_q.size() != 13 || nbits != 0) begin
      $display("test %s: lcd frame had %0d bytes and %0d spare bits, 13 bytes expected",
               cur_test, bytes_q.size(), nbits);
      errors++;
      return;
    end
    for (i = 0; i < 13; i++) begin
      if (dcs_q[i] !== ((i == 0 || i == 5 || i == 10) ? 1'b0 : 1'b1)) begin
        $display("test %s: wrong dc level on lcd byte %0d", cur_test, i);
        errors++;
      end
    end
    if (bytes_q[0] != lcd_caset || bytes_q[5] != lcd_raset || bytes_q[10] != lcd_ramwr) begin
      $display("test %s: lcd command bytes out of order", cur_test);
      errors++;
    end
    x = {bytes_q[1], bytes_q[2]};
    y = {bytes_q[6], bytes_q[7]};
    c = {bytes_q[11], bytes_q[12]};
    if ({bytes_q[3], bytes_q[4]} != x || {bytes_q[8], bytes_q[9]} != y) begin
      $display("test %s: window start and end differ for one pixel", cur_test);
      errors++;
    end
    if (exp_q.size() == 0) begin
      $display("test %s: extra pixel x=%0d y=%0d after the expected list ran out",
               cur_test, x, y);
      errors++;
      return;
    end
    exp = exp_q.pop_front();
    if (exp != {x, y, c}) begin
      $display("mismatch test %s pixel %0d expected x=%0d y=%0d c=%h actual x=%0d y=%0d c=%h",
               cur_test, pix_seen, exp[47:32], exp[31:16], exp[15:0], x, y, c);
      errors++;
    end
    pix_seen++;
  endtask

  // called when spi_busy falls
  task automatic close_test();
    if (exp_q.size() != 0) begin
      $display("test %s: %0d expected pixels never reached the lcd", cur_test, exp_q.size());
      errors++;
      exp_q.delete();
    end
    pix_seen = 0;
  endtask

endmodule
`default_nettype wire

/* polyline_top.sv */
`timescale 1ns/1ns
`default_nettype none
module polyline_top #(
  parameter int clk_div = 2
) (
  input  wire clk, arst_n,
  input  wire spi_csn, spi_sclk, spi_mosi,
  output wire spi_busy,  // back to the host
  output wire lcd_sclk, lcd_mosi, lcd_dc, lcd_csn, lcd_resn
);
  import polyline_pkg::*;

  // host bus
  wire                     wr;
  wire [addr_bits-1:0]     addr;
  wire [7:0]               wdata;
  // registers to plotter
  wire [buf_addr_bits-1:0] buf_addr;
  wire [coord_bits-1:0]    buf_data, color, len;
  wire                     plot;
  // plotter and rasteriser
  wire                     start, step, pix_valid, last;
  wire [coord_bits-1:0]    x0, y0, x1, y1, px, py;
  // plotter to lcd
  wire                     pix_go, lcd_busy;
  wire [coord_bits-1:0]    pix_x, pix_y, pix_color;

  spi_write_slave #(.addr_bits(addr_bits)) spi_write_slave_inst (
    .clk(clk), .arst_n(arst_n),
    .spi_csn(spi_csn), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi),
    .wr(wr), .addr(addr), .wdata(wdata)
  );

  polyline_regs polyline_regs_inst (
    .clk(clk), .arst_n(arst_n),
    .wr(wr), .addr(addr), .wdata(wdata),
    .buf_addr(buf_addr), .buf_data(buf_data),
    .color(color), .len(len), .plot(plot)
  );

  draw_polyline #(.buf_addr_bits(buf_addr_bits)) draw_polyline_inst (
    .clk(clk), .arst_n(arst_n),
    .plot(plot), .color(color), .len(len), .buf_data(buf_data),
    .px(px), .py(py), .pix_valid(pix_valid), .last(last), .lcd_busy(lcd_busy),
    .buf_addr(buf_addr), .busy(spi_busy), .start(start),
    .x0(x0), .y0(y0), .x1(x1), .y1(y1), .step(step),
    .pix_go(pix_go), .pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color)
  );

  line_raster line_raster_inst (
    .clk(clk), .arst_n(arst_n),
    .start(start), .x0(x0), .y0(y0), .x1(x1), .y1(y1), .step(step),
    .px(px), .py(py), .pix_valid(pix_valid), .last(last)
  );

  lcd_pixel_writer #(.clk_div(clk_div)) lcd_pixel_writer_inst (
    .clk(clk), .arst_n(arst_n),
    .pix_go(pix_go), .pix_x(pix_x), .pix_y(pix_y), .pix_color(pix_color),
    .lcd_busy(lcd_busy), .lcd_sclk(lcd_sclk), .lcd_mosi(lcd_mosi),
    .lcd_dc(lcd_dc), .lcd_csn(lcd_csn), .lcd_resn(lcd_resn)
  );

endmodule
`default_nettype wire

/* draw_polyline.sv */
`timescale 1ns/1ns
`default_nettype none
module draw_polyline #(
  parameter int buf_addr_bits = polyline_pkg::buf_addr_bits
) (
  input  wire                                clk, arst_n,
  input  wire                                plot,
  input  wire  [polyline_pkg::coord_bits-1:0] color, len, buf_data,
  input  wire  [polyline_pkg::coord_bits-1:0] px, py,
  input  wire                                pix_valid, last, lcd_busy,
  output logic [buf_addr_bits-1:0]           buf_addr,
  output logic                               busy,
  output logic                               start,
  output logic [polyline_pkg::coord_bits-1:0] x0, y0, x1, y1,
  output logic                               step, pix_go,
  output logic [polyline_pkg::coord_bits-1:0] pix_x, pix_y, pix_color
);
  import polyline_pkg::*;

  draw_state_t              state;
  logic [buf_addr_bits-2:0] seg;      // index of first point of the segment
  logic [coord_bits-3:0]    npts;     // len / 4
  logic [coord_bits-3:0]    seg_nxt;
  logic [2:0]               rcnt;     // read pipeline slot
  logic                     issue;    // hand one pixel over

  assign npts    = len[coord_bits-1:2];
  assign seg_nxt = seg + 1'b1;
  assign issue   = (state == ds_pix) && pix_valid && !lcd_busy && !pix_go && !step;

  // ******************************
  // control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ds_idle;
      busy     <= 1'b0;
      start    <= 1'b0;
      step     <= 1'b0;
      pix_go   <= 1'b0;
      seg      <= '0;
      rcnt     <= '0;
      buf_addr <= '0;
    end else begin
      start  <= 1'b0;
      step   <= 1'b0;
      pix_go <= 1'b0;
      case (state)
        ds_idle: begin
          if (plot) begin   // plots during busy never get here
            busy  <= 1'b1;
            seg   <= '0;
            state <= ds_check;
          end
        end
        ds_check: begin
          if (seg_nxt >= npts) begin
            state <= ds_drain; // no end point left, short len lands here too
          end else begin
            buf_addr <= {seg, 1'b0}; // x of point seg
            rcnt     <= '0;
            state    <= ds_read;
          end
        end
        ds_read: begin
          buf_addr <= buf_addr + 1'b1;
          rcnt     <= rcnt + 1'b1;
          if (rcnt == 3'd4) begin
            start <= 1'b1;
            state <= ds_pix;
          end
        end
        ds_pix: begin
          if (issue) begin
            pix_go <= 1'b1;
            step   <= 1'b1;
            if (last) begin
              seg   <= seg + 1'b1; // end point starts the next one
              state <= ds_check;
            end
          end
        end
        ds_drain: begin
          if (!lcd_busy && !pix_go) begin
            busy  <= 1'b0;
            state <= ds_idle;
          end
        end
        default: state <= ds_idle;
      endcase
    end
  end

  // buffer words land one clk after their address
  always_ff @(posedge clk) begin
    if (state == ds_read) begin
      case (rcnt)
        3'd1:    x0 <= buf_data;
        3'd2:    y0 <= buf_data;
        3'd3:    x1 <= buf_data;
        3'd4:    y1 <= buf_data;
        default: ;
      endcase
    end
    if (issue) begin
      pix_x     <= px;
      pix_y     <= py;
      pix_color <= color;
    end
  end

endmodule
`default_nettype wire

/* lcd_pixel_writer.sv */
`timescale 1ns/1ns
`default_nettype none
module lcd_pixel_writer #(
  parameter int clk_div = 2  // clk cycles per lcd bit, 2 or more
) (
  input  wire                                clk, arst_n,
  input  wire                                pix_go,
  input  wire  [polyline_pkg::coord_bits-1:0] pix_x, pix_y, pix_color,
  output logic                               lcd_busy,
  output logic                               lcd_sclk, lcd_mosi, lcd_dc,
  output logic                               lcd_csn, lcd_resn
);
  import polyline_pkg::*;

  localparam int               div_w    = $clog2(clk_div);
  localparam logic [div_w-1:0] div_half = div_w'(clk_div/2 - 1); // rising edge here
  localparam logic [div_w-1:0] div_last = div_w'(clk_div - 1);

  lcd_state_t            state, nxt_state;
  logic [coord_bits-1:0] x_q, y_q, c_q; // held for the whole burst
  logic [7:0]            shreg, nxt_byte;
  logic                  nxt_dc;
  logic [1:0]            bcnt;          // data byte within a group
  logic [2:0]            bit_cnt;
  logic [div_w-1:0]      div_cnt;

  assign lcd_busy = (state != ls_idle);
  assign lcd_mosi = shreg[7];

  // ******************************
  // byte that follows the current one
  always_comb begin
    nxt_state = state;
    nxt_byte  = 8'h00;
    nxt_dc    = 1'b1;
    case (state)
      ls_caset: begin
        nxt_state = ls_col;
        nxt_byte  = x_q[15:8];
      end
      ls_col: begin
        if (bcnt == 2'd3) begin
          nxt_state = ls_raset;
          nxt_byte  = lcd_raset;
          nxt_dc    = 1'b0;
        end else begin
          nxt_byte = bcnt[0] ? x_q[15:8] : x_q[7:0]; // start and end column
        end
      end
      ls_raset: begin
        nxt_state = ls_row;
        nxt_byte  = y_q[15:8];
      end
      ls_row: begin
        if (bcnt == 2'd3) begin
          nxt_state = ls_ramwr;
          nxt_byte  = lcd_ramwr;
          nxt_dc    = 1'b0;
        end else begin
          nxt_byte = bcnt[0] ? y_q[15:8] : y_q[7:0];
        end
      end
      ls_ramwr: begin
        nxt_state = ls_color;
        nxt_byte  = c_q[15:8];
      end
      ls_color: begin
        if (bcnt == 2'd1)
          nxt_state = ls_idle; // rgb565 done
        else
          nxt_byte = c_q[7:0];
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ls_idle;
      shreg    <= '0;
      bcnt     <= '0;
      bit_cnt  <= '0;
      div_cnt  <= '0;
      lcd_sclk <= 1'b1;  // idle high
      lcd_csn  <= 1'b1;
      lcd_dc   <= 1'b0;
      lcd_resn <= 1'b0;
    end else begin
      lcd_resn <= 1'b1;  // no init sequence, just release
      if (state == ls_idle) begin
        if (pix_go) begin
          state    <= ls_caset;
          shreg    <= lcd_caset;
          lcd_dc   <= 1'b0;
          lcd_csn  <= 1'b0;
          lcd_sclk <= 1'b0; // falling edge, msb out
          bcnt     <= '0;
          bit_cnt  <= '0;
          div_cnt  <= '0;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
        if (div_cnt == div_half)
          lcd_sclk <= 1'b1;
        if (div_cnt == div_last) begin
          div_cnt <= '0;
          bit_cnt <= bit_cnt + 1'b1; // wraps at byte end
          if (bit_cnt != 3'd7) begin
            shreg    <= {shreg[6:0], 1'b0};
            lcd_sclk <= 1'b0;
          end else if (nxt_state == ls_idle) begin
            state   <= ls_idle;
            lcd_csn <= 1'b1;  // sclk stays high
          end else begin
            state    <= nxt_state;
            shreg    <= nxt_byte;
            lcd_dc   <= nxt_dc;
            lcd_sclk <= 1'b0;
            bcnt     <= (nxt_state == state) ? bcnt + 1'b1 : 2'd0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pix_go && state == ls_idle) begin
      x_q <= pix_x;
      y_q <= pix_y;
      c_q <= pix_color;
    end
  end

  // the plotter has to wait for the previous burst
  assert property (@(posedge clk) disable iff (!arst_n) pix_go |-> !lcd_busy);

endmodule
`default_nettype wire

/* line_raster.sv */
`timescale 1ns/1ns
`default_nettype none
module line_raster (
  input  wire                                clk, arst_n,
  input  wire                                start,
  input  wire  [polyline_pkg::coord_bits-1:0] x0, y0, x1, y1,
  input  wire                                step,   // take current pixel
  output logic [polyline_pkg::coord_bits-1:0] px, py,
  output logic                               pix_valid,
  output logic                               last    // px,py is the end point
);
  import polyline_pkg::*;

  raster_state_t      state;
  logic signed [19:0] diff_x, diff_y;
  logic signed [19:0] abs_dx, neg_dy;
  logic signed [19:0] dx, dy;  // dy kept negative
  logic signed [19:0] err, e2;
  logic               x_neg, y_neg; // step direction
  logic               step_x, step_y;

  assign diff_x = $signed({4'b0, x1}) - $signed({4'b0, x0});
  assign diff_y = $signed({4'b0, y1}) - $signed({4'b0, y0});
  assign abs_dx = diff_x[19] ? -diff_x : diff_x;
  assign neg_dy = diff_y[19] ? diff_y : -diff_y;

  assign e2     = err <<< 1;
  assign step_x = (e2 >= dy);
  assign step_y = (e2 <= dx);

  assign pix_valid = (state == rs_run);
  assign last      = pix_valid && (px == x1) && (py == y1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      state <= rs_idle;
    else if (start)
      state <= rs_run;
    else if (step && last)
      state <= rs_idle; // end pixel consumed
  end

  // ******************************
  // bresenham stepper, err = dx + dy
  always_ff @(posedge clk) begin
    if (start) begin
      px    <= x0;
      py    <= y0;
      x_neg <= diff_x[19];
      y_neg <= diff_y[19];
      dx    <= abs_dx;
      dy    <= neg_dy;
      err   <= abs_dx + neg_dy;
    end else if (step && pix_valid && !last) begin
      if (step_x)
        px <= x_neg ? px - 1'b1 : px + 1'b1;
      if (step_y)
        py <= y_neg ? py - 1'b1 : py + 1'b1;
      err <= err + (step_x ? dy : 20'sd0) + (step_y ? dx : 20'sd0);
    end
  end

  // every pixel stays inside the box spanned by the end points
  assert property (@(posedge clk) disable iff (!arst_n) pix_valid |->
    (x_neg ? (px <= x0 && px >= x1) : (px >= x0 && px <= x1)) &&
    (y_neg ? (py <= y0 && py >= y1) : (py >= y0 && py <= y1)));

endmodule
`default_nettype wire

/* polyline_regs.sv */
`timescale 1ns/1ns
`default_nettype none
module polyline_regs (
  input  wire                                   clk, arst_n,
  input  wire                                   wr,
  input  wire  [polyline_pkg::addr_bits-1:0]     addr,
  input  wire  [7:0]                             wdata,
  input  wire  [polyline_pkg::buf_addr_bits-1:0] buf_addr,
  output logic [polyline_pkg::coord_bits-1:0]    buf_data,
  output logic [polyline_pkg::coord_bits-1:0]    color,
  output logic [polyline_pkg::coord_bits-1:0]    len,  // in bytes, 4 per point
  output logic                                  plot
);
  import polyline_pkg::*;

  logic [coord_bits-1:0] mem [0:(1<<buf_addr_bits)-1]; // x0 y0 x1 y1 ...
  logic [7:0]            msb_q; // even byte waits for its odd partner
  logic [15:0]           page;
  logic                  sel_buf, sel_reg;

  assign page    = addr[addr_bits-1 -: 16];
  assign sel_buf = wr && (page == page_points);
  assign sel_reg = wr && (page == page_regs);

  // point buffer, 8 bit in, 16 bit out
  always_ff @(posedge clk) begin
    if (sel_buf) begin
      if (addr[0])
        mem[addr[buf_addr_bits:1]] <= {msb_q, wdata};
      else
        msb_q <= wdata;
    end
    buf_data <= mem[buf_addr]; // one clk read latency
  end

  // ******************************
  // colour, length, plot strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      color <= '0;
      len   <= '0;
      plot  <= 1'b0;
    end else begin
      plot <= sel_reg && (addr[1:0] == 2'd3); // length lsb executes
      if (sel_reg) begin
        case (addr[1:0])
          2'd0: color[15:8] <= wdata;
          2'd1: color[7:0]  <= wdata;
          2'd2: len[15:8]   <= wdata;
          2'd3: len[7:0]    <= wdata;
        endcase
      end
    end
  end

endmodule
`default_nettype wire

/* spi_write_slave.sv */
`timescale 1ns/1ns
`default_nettype none
module spi_write_slave #(
  parameter int addr_bits = polyline_pkg::addr_bits
) (
  input  wire                  clk, arst_n,
  input  wire                  spi_csn, spi_sclk, spi_mosi,
  output logic                 wr,     // one clk per data byte
  output logic [addr_bits-1:0] addr,
  output logic [7:0]           wdata
);
  import polyline_pkg::*;

  logic [1:0] csn_s;
  logic [2:0] sclk_s;   // third tap for edge detect
  logic [1:0] mosi_s;
  logic       sclk_rise;
  logic [7:0] sh;       // bits shifted in so far
  logic [7:0] byte_in;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt; // 0 opcode, 1..4 address, 5 data
  spi_op_t    op;

  // two flop synchronisers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      csn_s  <= 2'b11;
      sclk_s <= 3'b000;
      mosi_s <= 2'b00;
    end else begin
      csn_s  <= {csn_s[0], spi_csn};
      sclk_s <= {sclk_s[1:0], spi_sclk};
      mosi_s <= {mosi_s[0], spi_mosi};
    end
  end

  assign sclk_rise = sclk_s[1] & ~sclk_s[2];
  assign byte_in   = {sh[6:0], mosi_s[1]}; // msb first

  // ******************************
  // frame decode
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt  <= '0;
      byte_cnt <= '0;
      op       <= op_write;
      wr       <= 1'b0;
      addr     <= '0;
    end else begin
      wr <= 1'b0;
      if (wr)
        addr <= addr + 1'b1; // next data byte goes one up
      if (csn_s[1]) begin
        bit_cnt  <= '0;      // new frame starts at the opcode
        byte_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7) begin
          if (byte_cnt != 3'd5)
            byte_cnt <= byte_cnt + 1'b1; // stick in data phase
          case (byte_cnt)
            3'd0:    op   <= spi_op_t'(byte_in);
            3'd5:    wr   <= (op == op_write); // reads are dropped
            default: addr <= {addr[addr_bits-9:0], byte_in};
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!csn_s[1] && sclk_rise) begin
      sh <= byte_in;
      if (bit_cnt == 3'd7 && byte_cnt == 3'd5)
        wdata <= byte_in;
    end
  end

  // strobes only come from inside a frame, even after sync delay
  assert property (@(posedge clk) disable iff (!arst_n) $rose(wr) |-> !spi_csn);

endmodule
`default_nettype wire

/* polyline_pkg.sv */
`default_nettype none
package polyline_pkg;

  // ******************************
  // widths
  localparam int addr_bits     = 32; // host address space
  localparam int buf_addr_bits = 10; // 1024 words of 16 bits
  localparam int coord_bits    = 16; // x, y, colour and length

  // upper address half selects the page
  localparam logic [15:0] page_points = 16'h1cdd; // point buffer, x/y msb first
  localparam logic [15:0] page_regs   = 16'h1cde; // colour, length, plot

  // st7789 commands
  localparam logic [7:0] lcd_caset = 8'h2a; // column window
  localparam logic [7:0] lcd_raset = 8'h2b; // row window
  localparam logic [7:0] lcd_ramwr = 8'h2c; // memory write

  // ******************************
  // host opcode, first byte of a frame
  typedef enum logic [7:0] {
    op_write = 8'h00,
    op_read  = 8'h01  // accepted, nothing driven back
  } spi_op_t;

  typedef enum logic [2:0] {
    ds_idle,   // wait for plot
    ds_check,  // more segments left?
    ds_read,   // four buffer words
    ds_pix,    // forward pixels
    ds_drain   // last burst on the lcd
  } draw_state_t;

  typedef enum logic {
    rs_idle,
    rs_run
  } raster_state_t;

  typedef enum logic [2:0] {
    ls_idle,
    ls_caset,
    ls_col,    // x msb, lsb, msb, lsb
    ls_raset,
    ls_row,    // same for y
    ls_ramwr,
    ls_color   // colour msb, lsb
  } lcd_state_t;

endpackage
`default_nettype wire
